// ==== flist.f ====
+incdir+source
source/clksup_pkg.sv
source/refclk_freq_meter.sv
source/clksel_fsm.sv
source/switch_event_fifo.sv
source/clk_supervisor.sv
testbench/clk_supervisor_chk.sv
testbench/tb_clk_supervisor.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the clock supervisor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module tb_clk_supervisor -o sim_clk_supervisor
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_clk_supervisor)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "STATUS: PASS"; then
    exit 0
fi
exit 1

// ==== source/clk_supervisor.sv ====
`timescale 1ns/1ps

module clk_supervisor (
    input  logic                   clk100_ext_buf,
    input  logic                   rst,
    input  logic                   ref_ext,        // External reference as data
    input  logic                   int_select,     // Force internal source
    input  logic                   pll_locked,     // Downstream PLL lock
    output logic                   sel_ext,
    output logic                   sel_int,
    output logic                   clk_ext_active,
    output logic                   locked,
    output logic                   evt_valid,
    input  logic                   evt_ready,
    output clksup_pkg::evt_code_t  evt_code,
    output clksup_pkg::win_idx_t   evt_win,
    output logic                   evt_overflow
);

    import clksup_pkg::*;

    logic       win_done;                          // Meter to FSM
    logic       win_good;
    win_idx_t   win_idx;
    logic       push;                              // FSM to queue
    evt_code_t  push_code;
    win_idx_t   push_win;

    //////////////////////////////////////////////////////////////////////
    // Reference rate measurement
    //////////////////////////////////////////////////////////////////////

    refclk_freq_meter u_meter (
        .clk100_ext_buf (clk100_ext_buf),
        .rst            (rst),
        .ref_ext        (ref_ext),
        .win_done       (win_done),
        .win_good       (win_good),
        .win_idx        (win_idx)
    );

    //////////////////////////////////////////////////////////////////////
    // Source selection
    //////////////////////////////////////////////////////////////////////

    clksel_fsm u_fsm (
        .clk100_ext_buf (clk100_ext_buf),
        .rst            (rst),
        .win_done       (win_done),
        .win_good       (win_good),
        .win_idx        (win_idx),
        .int_select     (int_select),
        .pll_locked     (pll_locked),
        .sel_ext        (sel_ext),
        .sel_int        (sel_int),
        .clk_ext_active (clk_ext_active),
        .locked         (locked),
        .push           (push),
        .push_code      (push_code),
        .push_win       (push_win)
    );

    // Event log only, never stalls the switch
    switch_event_fifo u_fifo (
        .clk100_ext_buf (clk100_ext_buf),
        .rst            (rst),
        .push           (push),
        .push_code      (push_code),
        .push_win       (push_win),
        .evt_valid      (evt_valid),
        .evt_ready      (evt_ready),
        .evt_code       (evt_code),
        .evt_win        (evt_win),
        .evt_overflow   (evt_overflow)
    );

endmodule

// ==== source/clksel_fsm.sv ====
`timescale 1ns/1ps
`include "clksup_params.svh"

module clksel_fsm (
    input  logic                   clk100_ext_buf,
    input  logic                   rst,
    input  logic                   win_done,       // Window end pulse
    input  logic                   win_good,       // Valid with win_done
    input  clksup_pkg::win_idx_t   win_idx,        // Event timestamp
    input  logic                   int_select,     // Force internal source
    input  logic                   pll_locked,
    output logic                   sel_ext,        // S0 style select
    output logic                   sel_int,        // S1 style select
    output logic                   clk_ext_active,
    output logic                   locked,
    output logic                   push,           // One cycle, no ready
    output clksup_pkg::evt_code_t  push_code,
    output clksup_pkg::win_idx_t   push_win
);

    import clksup_pkg::*;

    localparam int RUN_W = $clog2(`CLKSUP_GOOD_WINDOWS + 1);
    localparam logic [RUN_W-1:0] RUN_LAST = RUN_W'(`CLKSUP_GOOD_WINDOWS - 1);
    localparam guard_cnt_t GUARD_LAST = guard_cnt_t'(`CLKSUP_GUARD_CYCLES - 1);
    localparam evt_code_t EVT_SRC_INT  = evt_code_t'(`CLKSUP_EVT_SRC_INT);
    localparam evt_code_t EVT_SRC_EXT  = evt_code_t'(`CLKSUP_EVT_SRC_EXT);
    localparam evt_code_t EVT_EXT_LOST = evt_code_t'(`CLKSUP_EVT_EXT_LOST);

    sel_state_t        state;
    guard_cnt_t        guard_cnt;                  // Cycles spent in SEL_BREAK
    logic [RUN_W-1:0]  good_run;                   // Good windows in a row
    logic              ext_qual;                   // Reference trusted
    logic              target_ext;                 // Wanted source
    logic              lost_evt;                   // Qualification dropped now
    logic              lost_pend;                  // Lost event held one cycle
    logic              src_evt;                    // New select rises now

    //////////////////////////////////////////////////////////////////////
    // Qualification of the external reference
    //////////////////////////////////////////////////////////////////////

    assign lost_evt = win_done & ~win_good & ext_qual;

    always_ff @(posedge clk100_ext_buf) begin
        if (rst) begin
            good_run <= '0;
            ext_qual <= 1'b0;
        end else if (win_done) begin
            if (!win_good) begin
                good_run <= '0;                    // Any bad window disqualifies
                ext_qual <= 1'b0;
            end else if (good_run == RUN_LAST) begin
                ext_qual <= 1'b1;                  // Run complete
            end else begin
                good_run <= good_run + 1'b1;
            end
        end
    end

    assign clk_ext_active = ext_qual;
    assign target_ext     = ext_qual & ~int_select;

    //////////////////////////////////////////////////////////////////////
    // Break-before-make source switch
    //////////////////////////////////////////////////////////////////////

    // Target is sampled again at the end of the gap
    assign src_evt = (state == SEL_BREAK) && (guard_cnt == GUARD_LAST);

    always_ff @(posedge clk100_ext_buf) begin
        if (rst) begin
            state     <= SEL_START;
            guard_cnt <= '0;
            sel_ext   <= 1'b0;
            sel_int   <= 1'b0;
        end else begin
            case (state)
                SEL_START: begin
                    state     <= SEL_BREAK;        // One full gap before first source
                    guard_cnt <= '0;
                end
                SEL_BREAK: begin
                    if (src_evt) begin
                        state   <= target_ext ? SEL_EXT : SEL_INT;
                        sel_ext <= target_ext;     // Make
                        sel_int <= ~target_ext;
                    end else begin
                        guard_cnt <= guard_cnt + 1'b1;
                    end
                end
                SEL_INT: begin
                    if (target_ext) begin
                        state     <= SEL_BREAK;
                        sel_int   <= 1'b0;         // Break
                        guard_cnt <= '0;
                    end
                end
                SEL_EXT: begin
                    if (!target_ext) begin
                        state     <= SEL_BREAK;
                        sel_ext   <= 1'b0;         // Break
                        guard_cnt <= '0;
                    end
                end
                default: state <= SEL_START;
            endcase
        end
    end

    assign locked = ((state == SEL_INT) || (state == SEL_EXT)) && pll_locked;

    //////////////////////////////////////////////////////////////////////
    // Event pushes
    //////////////////////////////////////////////////////////////////////

    // A source event wins a shared cycle and the loss follows next
    always_ff @(posedge clk100_ext_buf) begin
        if (rst) begin
            push      <= 1'b0;
            lost_pend <= 1'b0;
        end else begin
            push <= 1'b0;
            if (src_evt) begin
                push      <= 1'b1;
                push_code <= target_ext ? EVT_SRC_EXT : EVT_SRC_INT;
                push_win  <= win_idx;
                lost_pend <= lost_pend | lost_evt;
            end else if (lost_evt || lost_pend) begin
                push      <= 1'b1;
                push_code <= EVT_EXT_LOST;
                push_win  <= win_idx;
                lost_pend <= 1'b0;
            end
        end
    end

endmodule

// ==== source/clksup_params.svh ====
`ifndef CLKSUP_PARAMS_SVH
`define CLKSUP_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Measurement window
//////////////////////////////////////////////////////////////////////
`define CLKSUP_WINDOW_CYCLES 64     // Clock cycles per window
`define CLKSUP_EDGE_MIN      6      // Fewest edges in a good window
`define CLKSUP_EDGE_MAX      10     // Most edges in a good window
`define CLKSUP_GOOD_WINDOWS  2      // Good windows in a row to qualify

//////////////////////////////////////////////////////////////////////
// Source switch and event log
//////////////////////////////////////////////////////////////////////
`define CLKSUP_GUARD_CYCLES  4      // Both selects low this long
`define CLKSUP_FIFO_DEPTH    4      // Event queue entries

// Event codes as stored in the queue
`define CLKSUP_EVT_SRC_INT   1      // Internal source now selected
`define CLKSUP_EVT_SRC_EXT   2      // External source now selected
`define CLKSUP_EVT_EXT_LOST  3      // External reference disqualified

`endif

// ==== source/clksup_pkg.sv ====
package clksup_pkg;

    //////////////////////////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////////////////////////

    // Rising reference edges seen in one window, saturating
    typedef logic [7:0] edge_cnt_t;

    // Window number, free running and wrapping
    // Also stamped onto every logged event
    typedef logic [7:0] win_idx_t;

    typedef logic [1:0] evt_code_t;     // Queue event code
    typedef logic [3:0] guard_cnt_t;    // Break-before-make gap timer

    //////////////////////////////////////////////////////////////////////
    // Selector state machine
    //////////////////////////////////////////////////////////////////////

    // SEL_START only exists right after reset
    // SEL_BREAK holds both selects low between sources
    typedef enum logic [1:0] {
        SEL_START = 2'd0,               // Out of reset, no source yet
        SEL_BREAK = 2'd1,               // Guard gap, both selects low
        SEL_INT   = 2'd2,               // Internal source driven
        SEL_EXT   = 2'd3                // External source driven
    } sel_state_t;

endpackage

// ==== source/refclk_freq_meter.sv ====
`timescale 1ns/1ps
`include "clksup_params.svh"

module refclk_freq_meter (
    input  logic                  clk100_ext_buf,
    input  logic                  rst,
    input  logic                  ref_ext,        // Async reference, treated as data
    output logic                  win_done,       // One pulse per window
    output logic                  win_good,       // Verdict of the last window
    output clksup_pkg::win_idx_t  win_idx         // Advances with each pulse
);

    import clksup_pkg::*;

    localparam int TIMER_W = $clog2(`CLKSUP_WINDOW_CYCLES);
    localparam logic [TIMER_W-1:0] TIMER_LAST = TIMER_W'(`CLKSUP_WINDOW_CYCLES - 1);
    localparam edge_cnt_t EDGE_MIN = edge_cnt_t'(`CLKSUP_EDGE_MIN);
    localparam edge_cnt_t EDGE_MAX = edge_cnt_t'(`CLKSUP_EDGE_MAX);

    logic                ref_meta;                // First sync stage
    logic                ref_sync;                // Second sync stage
    logic                ref_prev;                // Delayed for edge detect
    logic                ref_rise;
    logic [TIMER_W-1:0]  win_timer;
    logic                win_end;
    edge_cnt_t           edge_cnt;
    edge_cnt_t           edge_cnt_nxt;

    //////////////////////////////////////////////////////////////////////
    // Synchronizer and rising edge detect
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk100_ext_buf) begin
        if (rst) begin
            ref_meta <= 1'b0;
            ref_sync <= 1'b0;
            ref_prev <= 1'b0;
        end else begin
            ref_meta <= ref_ext;                  // May go metastable
            ref_sync <= ref_meta;
            ref_prev <= ref_sync;
        end
    end

    assign ref_rise = ref_sync & ~ref_prev;       // Edge lands 3 cycles late

    //////////////////////////////////////////////////////////////////////
    // Window timer and edge counter
    //////////////////////////////////////////////////////////////////////

    assign win_end = (win_timer == TIMER_LAST);

    // Count this cycle's edge too, stop at all ones
    assign edge_cnt_nxt = (ref_rise && (edge_cnt != '1)) ? edge_cnt + 1'b1 : edge_cnt;

    always_ff @(posedge clk100_ext_buf) begin
        if (rst) begin
            win_timer <= '0;
        end else if (win_end) begin
            win_timer <= '0;                      // Next window starts
        end else begin
            win_timer <= win_timer + 1'b1;
        end
    end

    always_ff @(posedge clk100_ext_buf) begin
        if (rst || win_end) begin
            edge_cnt <= '0;                       // Fresh count per window
        end else begin
            edge_cnt <= edge_cnt_nxt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Window verdict
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk100_ext_buf) begin
        if (rst) begin
            win_done <= 1'b0;
            win_good <= 1'b0;
            win_idx  <= '0;
        end else begin
            win_done <= win_end;                  // Single cycle pulse
            if (win_end) begin
                win_good <= (edge_cnt_nxt >= EDGE_MIN) && (edge_cnt_nxt <= EDGE_MAX);
                win_idx  <= win_idx + 1'b1;       // Wraps at 255
            end
        end
    end

endmodule

// ==== source/switch_event_fifo.sv ====
`timescale 1ns/1ps
`include "clksup_params.svh"

module switch_event_fifo (
    input  logic                   clk100_ext_buf,
    input  logic                   rst,
    input  logic                   push,           // No back-pressure on this side
    input  clksup_pkg::evt_code_t  push_code,
    input  clksup_pkg::win_idx_t   push_win,
    output logic                   evt_valid,
    input  logic                   evt_ready,
    output clksup_pkg::evt_code_t  evt_code,       // Head entry
    output clksup_pkg::win_idx_t   evt_win,
    output logic                   evt_overflow    // Sticky until rst
);

    import clksup_pkg::*;

    localparam int DEPTH = `CLKSUP_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    evt_code_t         code_mem [DEPTH];          // Event codes
    win_idx_t          win_mem  [DEPTH];          // Window stamps
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;                     // Occupancy
    logic              full;
    logic              wr_en;
    logic              rd_en;

    assign full  = (count == CNT_FULL);
    assign wr_en = push & ~full;                  // Dropped when full
    assign rd_en = evt_valid & evt_ready;         // Read handshake

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk100_ext_buf) begin
        if (wr_en) begin
            code_mem[wr_ptr] <= push_code;
            win_mem[wr_ptr]  <= push_win;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers, count and overflow
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk100_ext_buf) begin
        if (rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            evt_overflow <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // Both or neither
            endcase
            if (push && full) begin
                evt_overflow <= 1'b1;             // Event lost
            end
        end
    end

    // Head stays put until a handshake moves rd_ptr
    assign evt_valid = (count != '0);
    assign evt_code  = code_mem[rd_ptr];
    assign evt_win   = win_mem[rd_ptr];

endmodule

// ==== testbench/clk_supervisor_chk.sv ====
`timescale 1ns/1ps
`include "clksup_params.svh"

module clk_supervisor_chk (
    input  logic                   clk100_ext_buf,
    input  logic                   rst,
    input  logic                   sel_ext,
    input  logic                   sel_int,
    input  logic                   evt_valid,
    input  logic                   evt_ready,
    input  clksup_pkg::evt_code_t  evt_code,
    input  clksup_pkg::win_idx_t   evt_win,
    input  logic                   evt_overflow
);

    import clksup_pkg::*;

    logic        any_sel;                          // Either source driven
    guard_cnt_t  low_run;                          // Low cycles since the last select

    assign any_sel = sel_ext | sel_int;

    always_ff @(posedge clk100_ext_buf) begin
        if (rst || any_sel) begin
            low_run <= '0;
        end else if (low_run != '1) begin
            low_run <= low_run + 1'b1;             // Saturates
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Select pair
    //////////////////////////////////////////////////////////////////////

    sel_exclusive: assert property (@(posedge clk100_ext_buf) disable iff (rst)
        !(sel_ext && sel_int))
        else $error("Both selects high");

    // Gap since the last fall spans the guard time
    sel_guard_gap: assert property (@(posedge clk100_ext_buf) disable iff (rst)
        $rose(any_sel) |-> (low_run >= guard_cnt_t'(`CLKSUP_GUARD_CYCLES)))
        else $error("Select rose before guard gap ended");

    //////////////////////////////////////////////////////////////////////
    // Event read port
    //////////////////////////////////////////////////////////////////////

    evt_hold: assert property (@(posedge clk100_ext_buf) disable iff (rst)
        evt_valid && !evt_ready |=> evt_valid && $stable(evt_code) && $stable(evt_win))
        else $error("Head entry changed under back-pressure");

    ovf_sticky: assert property (@(posedge clk100_ext_buf) disable iff (rst)
        evt_overflow |=> evt_overflow)
        else $error("Overflow flag fell without reset");

endmodule

bind clk_supervisor clk_supervisor_chk u_chk (.*);

// ==== testbench/tb_clk_supervisor.sv ====
`timescale 1ns/1ps
`include "clksup_params.svh"

module tb_clk_supervisor;

    import clksup_pkg::*;

    localparam int NROWS   = 13;
    localparam int EV_INT  = `CLKSUP_EVT_SRC_INT;
    localparam int EV_EXT  = `CLKSUP_EVT_SRC_EXT;
    localparam int EV_LOST = `CLKSUP_EVT_EXT_LOST;

    typedef struct {
        int half;                                  // Reference half-period in cycles
        int isel;                                  // Drives int_select
        int pll;                                   // Drives pll_locked
        int rdy;                                   // Drives evt_ready
        int wins;                                  // Window ends to wait for
        int e_ext;                                 // Expected at phase end
        int e_int;
        int e_act;
        int e_lock;
        int e_ovf;
        int n_evt;                                 // Events pushed in this phase
        int ev0;
        int ev1;
        int keep;                                  // Zero when the events are dropped
    } row_t;

    logic       clk100_ext_buf;
    logic       rst;
    logic       ref_ext;
    logic       int_select;
    logic       pll_locked;
    logic       evt_ready;
    logic       sel_ext;
    logic       sel_int;
    logic       clk_ext_active;
    logic       locked;
    logic       evt_valid;
    evt_code_t  evt_code;
    win_idx_t   evt_win;
    logic       evt_overflow;

    row_t       rows [NROWS];
    evt_code_t  sb [$];                            // Expected read order
    win_idx_t   last_win;
    logic       have_last = 1'b0;
    int         ref_half = 0;                      // 0 stops the reference
    int         cycles = 0;
    int         limit = 1000000;

    clk_supervisor dut (.*);

    initial begin
        clk100_ext_buf = 1'b0;
        forever #2 clk100_ext_buf = ~clk100_ext_buf;   // 4 ns period
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped at %0t", $time);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED time=%0t signal=%s got=%0h expected=%0h",
                     $time, name, got, exp);
            fail_run("Value mismatch");
        end
    endtask

    function automatic void load_table();
        //          half isel pll rdy wins  ext int act lck ovf  n  ev0      ev1      keep
        rows[0]  = '{0,   0,   1,  1,  1,    0,  1,  0,  1,  0,   1, EV_INT,  0,       1};
        rows[1]  = '{4,   0,   1,  1,  3,    1,  0,  1,  1,  0,   1, EV_EXT,  0,       1};
        rows[2]  = '{0,   0,   1,  1,  1,    0,  1,  0,  1,  0,   2, EV_LOST, EV_INT,  1};
        rows[3]  = '{4,   0,   1,  1,  3,    1,  0,  1,  1,  0,   1, EV_EXT,  0,       1};
        rows[4]  = '{1,   0,   1,  1,  1,    0,  1,  0,  1,  0,   2, EV_LOST, EV_INT,  1};
        rows[5]  = '{4,   0,   1,  1,  3,    1,  0,  1,  1,  0,   1, EV_EXT,  0,       1};
        rows[6]  = '{4,   1,   1,  1,  1,    0,  1,  1,  1,  0,   1, EV_INT,  0,       1};
        rows[7]  = '{4,   0,   0,  1,  1,    1,  0,  1,  0,  0,   1, EV_EXT,  0,       1};
        rows[8]  = '{4,   1,   1,  0,  1,    0,  1,  1,  1,  0,   1, EV_INT,  0,       1};
        rows[9]  = '{4,   0,   1,  0,  1,    1,  0,  1,  1,  0,   1, EV_EXT,  0,       1};
        rows[10] = '{0,   0,   1,  0,  1,    0,  1,  0,  1,  0,   2, EV_LOST, EV_INT,  1};
        rows[11] = '{4,   0,   1,  0,  3,    1,  0,  1,  1,  1,   1, EV_EXT,  0,       0};
        rows[12] = '{4,   0,   1,  1,  1,    1,  0,  1,  1,  1,   0, 0,       0,       1};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference generator, timeout and event scoreboard
    //////////////////////////////////////////////////////////////////////

    always begin
        if (ref_half == 0) begin
            @(posedge clk100_ext_buf);
            ref_ext <= 1'b0;                       // Stopped reference
        end else begin
            repeat (ref_half) @(posedge clk100_ext_buf);
            ref_ext <= ~ref_ext;
        end
    end

    always @(posedge clk100_ext_buf) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            fail_run("Timeout, the run took longer than the cycle limit");
        end
    end

    // Handshake seen with pre-edge values
    always @(posedge clk100_ext_buf) begin
        if (!rst && evt_valid && evt_ready) begin
            if (sb.size() == 0) begin
                fail_run("An event was read while none was expected");
            end else begin
                check_val("evt_code", evt_code, sb.pop_front());
                if (have_last && (8'(evt_win - last_win) >= 8'd128)) begin
                    fail_run("Event window index went backwards");
                end
                last_win  = evt_win;
                have_last = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int seen;
        int total;
        load_table();
        total = 0;
        for (int r = 0; r < NROWS; r++) begin
            total += rows[r].wins;
        end
        limit = total * `CLKSUP_WINDOW_CYCLES + 200;
        rst        = 1'b1;
        ref_ext    = 1'b0;
        int_select = 1'b0;
        pll_locked = 1'b0;
        evt_ready  = 1'b1;

        repeat (2) @(posedge clk100_ext_buf);
        @(negedge clk100_ext_buf);
        check_val("sel_ext", sel_ext, 0);          // Reset values
        check_val("sel_int", sel_int, 0);
        check_val("locked", locked, 0);
        check_val("evt_valid", evt_valid, 0);
        check_val("evt_overflow", evt_overflow, 0);
        check_val("clk_ext_active", clk_ext_active, 0);
        @(posedge clk100_ext_buf);
        rst <= 1'b0;                               // Third reset edge

        for (int r = 0; r < NROWS; r++) begin
            @(posedge clk100_ext_buf);
            ref_half   <= rows[r].half;
            int_select <= rows[r].isel[0];
            pll_locked <= rows[r].pll[0];
            evt_ready  <= rows[r].rdy[0];
            if (rows[r].keep != 0 && rows[r].n_evt > 0) begin
                sb.push_back(evt_code_t'(rows[r].ev0));
            end
            if (rows[r].keep != 0 && rows[r].n_evt > 1) begin
                sb.push_back(evt_code_t'(rows[r].ev1));
            end
            seen = 0;
            while (seen < rows[r].wins) begin
                @(negedge clk100_ext_buf);
                if (dut.win_done) begin
                    seen++;
                end
            end
            repeat (10) @(negedge clk100_ext_buf);  // Switch settles
            check_val("sel_ext", sel_ext, rows[r].e_ext);
            check_val("sel_int", sel_int, rows[r].e_int);
            check_val("clk_ext_active", clk_ext_active, rows[r].e_act);
            check_val("locked", locked, rows[r].e_lock);
            check_val("evt_overflow", evt_overflow, rows[r].e_ovf);
        end

        while (sb.size() != 0) begin
            @(negedge clk100_ext_buf);             // Drain the log
        end
        repeat (4) @(negedge clk100_ext_buf);
        check_val("evt_valid", evt_valid, 0);      // Nothing left over
        $display("STATUS: PASS");
        $finish;
    end

endmodule
